/* Bender.yml */
package:
  name: rvMulticycle

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rvPkg.sv
      - hdl/registerFile.sv
      - hdl/controlFsm.sv
      - hdl/instrDecode.sv
      - hdl/aluUnit.sv
      - hdl/busPort.sv
      - hdl/rvCore.sv
  - target: test
    include_dirs:
      - hdl
      - test
    files:
      - test/rvCoreTb.sv

/* hdl/aluUnit.sv */
module aluUnit import rvPkg::*; (
  input  logic   Clock,
  input  logic   arstN,
  input  logic   resultLoad,
  input  logic   useImm,
  input  aluOp_t aluOp,
  input  word_t  rs1Data,
  input  word_t  rs2Data,
  input  word_t  imm,
  output word_t  result
);

  word_t      opB;
  word_t      aluOut;
  logic [4:0] shamt;

  assign opB   = useImm ? imm : rs2Data;
  assign shamt = opB[4:0];

  always_comb begin
    case (aluOp)
      aluAdd: aluOut = rs1Data + opB;  // wraps
      aluSub: aluOut = rs1Data - opB;
      aluSll: aluOut = rs1Data << shamt;
      aluSrl: aluOut = rs1Data >> shamt;
      aluSra: aluOut = word_t'($signed(rs1Data) >>> shamt);
      aluXor: aluOut = rs1Data ^ opB;
      aluOr:  aluOut = rs1Data | opB;
      aluAnd: aluOut = rs1Data & opB;
      default: aluOut = rs1Data + opB;
    endcase
  end

  // result feeds write-back and the store address
  always_ff @(posedge Clock or negedge arstN) begin
    if (!arstN) result <= '0;
    else if (resultLoad) result <= aluOut;
  end

endmodule

/* hdl/busPort.sv */
`include "rv_cfg.svh"

module busPort import rvPkg::*; (
  input  logic  Clock,
  input  logic  arstN,
  input  logic  fetch,
  input  logic  store,
  input  word_t storeAddr,
  input  word_t storeData,
  output word_t ADDR,
  output word_t DOUT,
  output logic  W
);

  word_t pc;

  always_ff @(posedge Clock or negedge arstN) begin
    if (!arstN) begin
      pc   <= word_t'(`RV_RESET_PC);
      ADDR <= '0;
      DOUT <= '0;
      W    <= 1'b0;
    end else begin
      W <= store;  // high for the first cycle of the next fetch
      if (fetch) begin
        ADDR <= pc;
        pc   <= pc + word_t'(`RV_PC_STEP);
      end else if (store) begin
        ADDR <= storeAddr;
        DOUT <= storeData;
      end
    end
  end

endmodule

/* hdl/controlFsm.sv */
module controlFsm import rvPkg::*; (
  input  logic Clock,
  input  logic arstN,
  input  logic Run,
  input  logic isAlu,
  input  logic isStore,
  output logic fetch,
  output logic irLoad,
  output logic resultLoad,
  output logic regWrite,
  output logic store
);

  cpuState_t state;
  cpuState_t nextState;

  always_ff @(posedge Clock or negedge arstN) begin
    if (!arstN) state <= stFetch;
    else state <= nextState;
  end

  always_comb begin
    nextState = state;
    case (state)
      stFetch: begin
        if (Run) nextState = stMemWait;  // only stall point
      end
      stMemWait: nextState = stDecode;
      stDecode: nextState = stExec;
      stExec: nextState = stAccess;
      stAccess: begin
        // a store is done here, one cycle short of the others
        if (isStore) nextState = stFetch;
        else nextState = stWriteBack;
      end
      stWriteBack: nextState = stFetch;
      default: nextState = stFetch;
    endcase
  end

  // one-cycle control pulses
  always_comb begin
    fetch      = 1'b0;
    irLoad     = 1'b0;
    resultLoad = 1'b0;
    regWrite   = 1'b0;
    store      = 1'b0;
    case (state)
      stFetch: fetch = Run;
      stDecode: irLoad = 1'b1;
      stExec: resultLoad = 1'b1;
      stAccess: store = isStore;
      stWriteBack: regWrite = isAlu;  // unsupported ops write nothing
      default: ;
    endcase
  end

endmodule

/* hdl/instrDecode.sv */
`include "rv_cfg.svh"

module instrDecode import rvPkg::*; (
  input  logic    Clock,
  input  logic    arstN,
  input  logic    irLoad,
  input  word_t   DIN,
  output regIdx_t rs1,
  output regIdx_t rs2,
  output regIdx_t rd,
  output word_t   imm,
  output logic    useImm,
  output logic    isAlu,
  output logic    isStore,
  output aluOp_t  aluOp
);

  word_t   ir;
  opcode_t opcode;
  logic [2:0] funct3;
  logic    alt;  // funct7 bit 5
  word_t   immI;
  word_t   immS;
  aluOp_t  f3Op;
  logic    f3Ok;

  always_ff @(posedge Clock or negedge arstN) begin
    if (!arstN) ir <= '0;
    else if (irLoad) ir <= DIN;  // word on DIN captured at end of stDecode
  end

  assign opcode = opcode_t'(ir[6:0]);
  assign funct3 = ir[14:12];
  assign alt    = ir[30];
  assign rd     = ir[11:7];
  assign rs1    = ir[19:15];
  assign rs2    = ir[24:20];

  assign immI = {{(`RV_XLEN-12){ir[31]}}, ir[31:20]};
  assign immS = {{(`RV_XLEN-12){ir[31]}}, ir[31:25], ir[11:7]};

  // funct3 map shared by both ALU forms
  always_comb begin
    f3Op = aluAdd;
    f3Ok = 1'b1;
    case (funct3)
      3'b000: f3Op = (alt && opcode == opAlu) ? aluSub : aluAdd;  // no subi
      3'b001: f3Op = aluSll;
      3'b100: f3Op = aluXor;
      3'b101: f3Op = alt ? aluSra : aluSrl;
      3'b110: f3Op = aluOr;
      3'b111: f3Op = aluAnd;
      default: f3Ok = 1'b0;  // slt, sltu
    endcase
  end

  always_comb begin
    isAlu   = 1'b0;
    isStore = 1'b0;
    useImm  = 1'b0;
    aluOp   = f3Op;
    imm     = immI;
    case (opcode)
      opAlu: isAlu = f3Ok;
      opAluImm: begin
        isAlu  = f3Ok;
        useImm = 1'b1;
      end
      opStore: begin
        isStore = (funct3 == 3'b010);  // sw only
        useImm  = 1'b1;
        aluOp   = aluAdd;  // address = rs1 + imm
        imm     = immS;
      end
      default: ;
    endcase
  end

endmodule

/* hdl/registerFile.sv */
`include "rv_cfg.svh"

module registerFile (
  input  logic               Clock,
  input  logic               arstN,
  input  logic               regWrite,
  input  logic [4:0]         rs1,
  input  logic [4:0]         rs2,
  input  logic [4:0]         rd,
  input  logic [`RV_XLEN-1:0] writeData,
  output logic [`RV_XLEN-1:0] rs1Data,
  output logic [`RV_XLEN-1:0] rs2Data
);

  logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

  always_ff @(posedge Clock or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < `RV_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (regWrite && rd != 5'd0) begin
      regs[rd] <= writeData;  // x0 stays at its reset value
    end
  end

  // combinational read ports
  assign rs1Data = regs[rs1];
  assign rs2Data = regs[rs2];

endmodule

/* hdl/rvCore.sv */
module rvCore import rvPkg::*; (
  input  logic  Clock,
  input  logic  arstN,
  input  logic  Run,
  input  word_t DIN,
  output word_t ADDR,
  output word_t DOUT,
  output logic  W
);

  // control pulses
  logic fetch;
  logic irLoad;
  logic resultLoad;
  logic regWrite;
  logic store;

  // decode outputs
  logic    isAlu;
  logic    isStore;
  logic    useImm;
  regIdx_t rs1;
  regIdx_t rs2;
  regIdx_t rd;
  word_t   imm;
  aluOp_t  aluOp;

  word_t rs1Data;
  word_t rs2Data;
  word_t result;

  controlFsm controlFsm_i (
    .Clock      (Clock),
    .arstN      (arstN),
    .Run        (Run),
    .isAlu      (isAlu),
    .isStore    (isStore),
    .fetch      (fetch),
    .irLoad     (irLoad),
    .resultLoad (resultLoad),
    .regWrite   (regWrite),
    .store      (store)
  );

  instrDecode instrDecode_i (
    .Clock   (Clock),
    .arstN   (arstN),
    .irLoad  (irLoad),
    .DIN     (DIN),
    .rs1     (rs1),
    .rs2     (rs2),
    .rd      (rd),
    .imm     (imm),
    .useImm  (useImm),
    .isAlu   (isAlu),
    .isStore (isStore),
    .aluOp   (aluOp)
  );

  registerFile registerFile_i (
    .Clock     (Clock),
    .arstN     (arstN),
    .regWrite  (regWrite),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (rd),
    .writeData (result),
    .rs1Data   (rs1Data),
    .rs2Data   (rs2Data)
  );

  aluUnit aluUnit_i (
    .Clock      (Clock),
    .arstN      (arstN),
    .resultLoad (resultLoad),
    .useImm     (useImm),
    .aluOp      (aluOp),
    .rs1Data    (rs1Data),
    .rs2Data    (rs2Data),
    .imm        (imm),
    .result     (result)
  );

  busPort busPort_i (
    .Clock     (Clock),
    .arstN     (arstN),
    .fetch     (fetch),
    .store     (store),
    .storeAddr (result),   // rs1 + S immediate
    .storeData (rs2Data),
    .ADDR      (ADDR),
    .DOUT      (DOUT),
    .W         (W)
  );

endmodule

/* hdl/rvPkg.sv */
`include "rv_cfg.svh"

package rvPkg;

  typedef logic [`RV_XLEN-1:0] word_t;

  typedef logic [4:0] regIdx_t;

  // major opcodes handled by the core
  typedef enum logic [6:0] {
    opAlu    = 7'b0110011,
    opAluImm = 7'b0010011,
    opStore  = 7'b0100011
  } opcode_t;

  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluSll,
    aluSrl,
    aluSra,
    aluXor,
    aluOr,
    aluAnd
  } aluOp_t;

  // six control steps per instruction
  typedef enum logic [2:0] {
    stFetch     = 3'd0,
    stMemWait   = 3'd1,
    stDecode    = 3'd2,
    stExec      = 3'd3,
    stAccess    = 3'd4,
    stWriteBack = 3'd5
  } cpuState_t;

endpackage

/* hdl/rv_cfg.svh */
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// data and address width
`define RV_XLEN 32

// architectural registers, x0 included
`define RV_REG_COUNT 32

// byte address step between instruction words
`define RV_PC_STEP 4

// first fetch address
`define RV_RESET_PC 0

`endif

/* rvMulticycle.f */
+incdir+hdl
+incdir+test
hdl/rvPkg.sv
hdl/registerFile.sv
hdl/controlFsm.sv
hdl/instrDecode.sv
hdl/aluUnit.sv
hdl/busPort.sv
hdl/rvCore.sv
test/rvCoreTb.sv

/* test/rvTests.svh */
`ifndef RV_TESTS_SVH
`define RV_TESTS_SVH

function automatic word_t sext12(logic [11:0] v);
  return {{20{v[11]}}, v};
endfunction

// RV32I semantics of the kept operations
function automatic word_t aluModel(logic [2:0] f3, logic alt, word_t a, word_t b);
  logic signed [31:0] sa;
  sa = a;
  case (f3)
    3'b000: return alt ? a - b : a + b;
    3'b001: return a << b[4:0];
    3'b100: return a ^ b;
    3'b101: begin
      if (alt) return sa >>> b[4:0];
      return a >> b[4:0];
    end
    3'b110: return a | b;
    default: return a & b;
  endcase
endfunction

task automatic putWord(word_t w);
  mem[pcIdx] = w;
  pcIdx++;
endtask

task automatic aluImm(logic [2:0] f3, regIdx_t rd, regIdx_t rs1, logic [11:0] imm);
  logic alt;
  alt = (f3 == 3'b101) && imm[10];  // no subi, only srai
  putWord({imm, rs1, f3, rd, opAluImm});
  if (rd != 0 && f3 != 3'b010 && f3 != 3'b011) begin
    model[rd] = aluModel(f3, alt, model[rs1], sext12(imm));
  end
endtask

task automatic aluReg(logic [2:0] f3, logic alt, regIdx_t rd, regIdx_t rs1, regIdx_t rs2);
  putWord({1'b0, alt, 5'b0, rs2, rs1, f3, rd, opAlu});
  if (rd != 0 && f3 != 3'b010 && f3 != 3'b011) begin
    model[rd] = aluModel(f3, alt, model[rs1], model[rs2]);
  end
endtask

// sw rs2, off(x0)
task automatic storeWord(regIdx_t rs2, logic [11:0] off);
  putWord({off[11:5], rs2, 5'd0, 3'b010, off[4:0], opStore});
  expAddr.push_back(sext12(off));
  expData.push_back(model[rs2]);
endtask

task automatic loadRandom(regIdx_t rd);
  aluImm(3'b000, rd, 5'd0, 12'(randBits(12)));
  aluImm(3'b001, rd, rd, 12'd11);
  aluImm(3'b100, rd, rd, 12'(randBits(12)));
  aluImm(3'b001, rd, rd, 12'd10);
  aluImm(3'b110, rd, rd, 12'(randBits(12)));
endtask

task automatic startProgram();
  pcIdx = 0;
  fillMemory();
  for (int i = 0; i < 32; i++) begin
    model[i] = '0;
  end
  expAddr.delete();
  expData.delete();
endtask

task automatic runProgram();
  cycleLimit = cycles + ResetCycles + 6 * pcIdx + Margin;
  applyReset();
  @(negedge Clock);
  Run = 1'b1;
  while (gotAddr.size() < expAddr.size()) @(negedge Clock);
  repeat (12) @(negedge Clock);  // trailing fill words must not store
  Run = 1'b0;
  checkVal("store count", word_t'(gotAddr.size()), word_t'(expAddr.size()));
  for (int i = 0; i < expAddr.size(); i++) begin
    checkVal($sformatf("ADDR[%0d]", i), gotAddr[i], expAddr[i]);
    checkVal($sformatf("DOUT[%0d]", i), gotData[i], expData[i]);
  end
endtask

task automatic testResetFetch();
  word_t prevAddr;
  int    prevCyc;
  startProgram();
  for (int i = 0; i < 4; i++) begin
    aluImm(3'b000, regIdx_t'(i + 1), 5'd0, 12'(i + 7));
  end
  cycleLimit = cycles + ResetCycles + 6 * 5 + Margin;
  applyReset();
  repeat (8) begin
    @(negedge Clock);
    checkVal("W", word_t'(W), '0);
    checkVal("ADDR", ADDR, '0);
  end
  @(negedge Clock);
  Run = 1'b1;
  prevAddr = ADDR;
  prevCyc  = cycles;
  // first fetch is at 0, so ADDR only moves from the second one on
  for (int k = 1; k <= 4; k++) begin
    while (ADDR == prevAddr) @(negedge Clock);
    checkVal("ADDR", ADDR, word_t'(k * `RV_PC_STEP));
    if (k > 1) checkVal("fetch spacing", word_t'(cycles - prevCyc), 32'd6);
    prevAddr = ADDR;
    prevCyc  = cycles;
  end
  @(negedge Clock);
  Run = 1'b0;
endtask

task automatic testImmBuild();
  startProgram();
  for (int r = 1; r <= 4; r++) begin
    loadRandom(regIdx_t'(r));
  end
  aluImm(3'b101, 5'd5, 5'd1, {7'b0100000, 5'(randBits(5))});  // srai
  aluImm(3'b101, 5'd6, 5'd2, {7'b0000000, 5'(randBits(5))});  // srli
  aluImm(3'b111, 5'd7, 5'd3, 12'(randBits(12)));
  aluImm(3'b000, 5'd8, 5'd4, 12'(randBits(12)));
  for (int r = 1; r <= 8; r++) begin
    storeWord(regIdx_t'(r), 12'(12'hf80 + 4 * r));  // negative offsets
  end
  runProgram();
endtask

task automatic testRegOps();
  logic [2:0] f3s [8];
  logic       alts [8];
  f3s  = '{3'b000, 3'b000, 3'b100, 3'b110, 3'b111, 3'b001, 3'b101, 3'b101};
  alts = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
  startProgram();
  loadRandom(5'd1);
  loadRandom(5'd2);
  for (int k = 0; k < 8; k++) begin
    aluReg(f3s[k], alts[k], regIdx_t'(10 + k), 5'd1, 5'd2);
    storeWord(regIdx_t'(10 + k), 12'(12'h040 + 4 * k));
  end
  runProgram();
endtask

task automatic testZeroUnsupported();
  startProgram();
  loadRandom(5'd1);
  loadRandom(5'd2);
  aluImm(3'b000, 5'd0, 5'd1, 12'h123);
  aluReg(3'b000, 1'b0, 5'd0, 5'd1, 5'd2);
  storeWord(5'd0, 12'h010);
  aluReg(3'b100, 1'b0, 5'd5, 5'd1, 5'd2);
  aluImm(3'b010, 5'd5, 5'd1, 12'h7ff);      // slti
  aluReg(3'b011, 1'b0, 5'd5, 5'd1, 5'd2);   // sltu
  putWord({20'habcde, 5'd5, 7'b0110111});   // lui x5
  storeWord(5'd5, 12'h014);
  runProgram();
endtask

task automatic testStoreSpacing();
  startProgram();
  loadRandom(5'd3);
  storeWord(5'd3, 12'h020);
  aluImm(3'b110, 5'd3, 5'd3, 12'(randBits(12)));
  storeWord(5'd3, 12'h024);
  runProgram();
  checkVal("store spacing", word_t'(storeCyc[1] - storeCyc[0]), 32'd11);
endtask

`endif

/* test/rvCoreTb.sv */
`include "rv_cfg.svh"

module rvCoreTb import rvPkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MemWords    = 256;
  localparam int ResetCycles = 16;
  localparam int Margin      = 40;

  logic  Clock;
  logic  arstN;
  logic  Run;
  word_t DIN;
  word_t ADDR;
  word_t DOUT;
  logic  W;

  word_t mem [MemWords];
  int    pcIdx;
  word_t model [32];  // expected register contents
  word_t expAddr [$];
  word_t expData [$];
  word_t gotAddr [$];
  word_t gotData [$];
  int    storeCyc [$];

  int          cycles     = 0;
  int          cycleLimit = 60;
  int          errors     = 0;
  int          checks     = 0;
  logic [31:0] lfsr       = 32'h5e31_28e6;
  logic        wPrev      = 1'b0;

  rvCore dut_i (
    .Clock (Clock),
    .arstN (arstN),
    .Run   (Run),
    .DIN   (DIN),
    .ADDR  (ADDR),
    .DOUT  (DOUT),
    .W     (W)
  );

  initial Clock = 1'b0;
  always #5 Clock = ~Clock;

  always @(posedge Clock) cycles++;

  // memory answers with the word at the current bus address
  always @(negedge Clock) begin
    DIN = mem[ADDR[9:2]];
  end

  // store monitor
  always @(negedge Clock) begin
    if (arstN && W) begin
      gotAddr.push_back(ADDR);
      gotData.push_back(DOUT);
      storeCyc.push_back(cycles);
      if (wPrev) begin
        errors++;
        $display("write strobe W stayed high for more than one cycle");
      end
    end
    wPrev = W;
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsrBit();
    logic fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic word_t randBits(int n);
    word_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsrBit()};
    end
    return v;
  endfunction

  // unknown opcode 0001011 with upper bits hashed from the byte address
  function automatic word_t fillWord(int idx);
    word_t a;
    a = word_t'(idx) << 2;
    return ((a * 32'h9e37_79b9) & ~32'h7f) | 32'h0000_000b;
  endfunction

  task automatic fillMemory();
    for (int i = 0; i < MemWords; i++) begin
      mem[i] = fillWord(i);
    end
  endtask

  task automatic checkVal(string name, word_t got, word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic applyReset();
    @(negedge Clock);
    arstN = 1'b0;
    Run   = 1'b0;
    gotAddr.delete();
    gotData.delete();
    storeCyc.delete();
    repeat (ResetCycles) @(negedge Clock);
    arstN = 1'b1;
  endtask

  task automatic printSummary();
    $display("%0d checks, %0d errors", checks, errors);
  endtask

  `include "rvTests.svh"

  initial begin : watchdog
    while (cycles < cycleLimit) @(posedge Clock);
    errors++;
    $display("timeout after %0d cycles, the expected stores did not arrive", cycles);
    printSummary();
    $display("Errors found");
    $finish;
  end

  initial begin
    arstN = 1'b0;
    Run   = 1'b0;
    DIN   = '0;
    fillMemory();
    testResetFetch();
    testImmBuild();
    testRegOps();
    testZeroUnsupported();
    testStoreSpacing();
    printSummary();
    if (errors == 0) $display("No errors");
    else $display("Errors found");
    $finish;
  end

endmodule
